/* mcpu.f */
source/mcpu_pkg.sv
source/fetch_unit.sv
source/decode_stage.sv
source/reg_file.sv
source/alu_stage.sv
source/mul_pipe.sv
source/hazard_control.sv
source/mcpu_top.sv
tests/mcpu_tb.sv

/* tests/mcpu_tb.sv */
`timescale 1ns/1ps

module mcpu_tb;

   localparam int ROM_WORDS = 256;
   localparam int QDEPTH    = 64;
   localparam int DRAIN_MAX = 2000;   // Cycles a program may take to drain

   logic                      clk;
   logic                      if_id_reset;
   logic [mcpu_pkg::XLEN-1:0] imem_addr;
   mcpu_pkg::instr_t          imem_data;
   mcpu_pkg::wb_t             retire;

   logic [31:0] rom [ROM_WORDS];
   logic [31:0] model_regs [32];
   logic [31:0] exp_val [32][QDEPTH];   // Per register, in program order
   int          exp_head [32], exp_tail [32];
   int          prog_len, errors, checks, tests_run, tests_failed;
   logic [15:0] lfsr;
   logic [4:0]  d, s1, s2;

   assign imem_data = (imem_addr < ROM_WORDS * 4) ? rom[imem_addr[9:2]] : '0;

   mcpu_top uut (.clk(clk), .if_id_reset(if_id_reset), .imem_addr(imem_addr),
                 .imem_data(imem_data), .retire(retire));

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Retire settles well before the falling edge
   always @(negedge clk) begin
      assert (!(uut.alu_wb.valid && uut.mul_wb.valid)) else begin
         $display("ALU and MUL results both reached the register file in one cycle");
         errors++;
      end
      if (retire.valid) begin
         checks++;
         assert (!if_id_reset && exp_head[retire.dest] < exp_tail[retire.dest]) else begin
            $display("Register %0d was written while no write was due", retire.dest);
            errors++;
         end
         if (exp_head[retire.dest] < exp_tail[retire.dest]) begin
            assert (retire.data === exp_val[retire.dest][exp_head[retire.dest]]) else begin
               $display("Error: retire.data of r%0d expected %h, got %h", retire.dest,
                        exp_val[retire.dest][exp_head[retire.dest]], retire.data);
               errors++;
            end
            exp_head[retire.dest]++;
         end
      end
   end

   // Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [31:0] random_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
         v    = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   function automatic logic [31:0] rtype(input logic [5:0] fn, input logic [4:0] rd, rs, rt);
      return {mcpu_pkg::OP_RTYPE, rs, rt, rd, 5'd0, fn};
   endfunction

   function automatic logic [31:0] itype(input logic [5:0] op, input logic [4:0] rt, rs,
                                         input logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   // Append to the ROM and execute on the reference model
   task automatic emit(input logic [31:0] word);
      logic [31:0] a, b, res;
      logic [4:0]  dst;
      logic        wr;
      rom[prog_len] = word;
      prog_len++;
      a   = model_regs[word[25:21]];
      b   = model_regs[word[20:16]];
      dst = (word[31:26] == mcpu_pkg::OP_RTYPE) ? word[15:11] : word[20:16];
      wr  = 1'b1;
      res = '0;
      case (word[31:26])
         mcpu_pkg::OP_RTYPE: begin
            case (word[5:0])
               mcpu_pkg::FN_ADD: res = a + b;
               mcpu_pkg::FN_SUB: res = a - b;
               mcpu_pkg::FN_AND: res = a & b;
               mcpu_pkg::FN_OR:  res = a | b;
               mcpu_pkg::FN_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
               mcpu_pkg::FN_MUL: res = a * b;   // Low word of the product
               default:          wr = 1'b0;
            endcase
         end
         mcpu_pkg::OP_ADDI: res = a + {{16{word[15]}}, word[15:0]};
         mcpu_pkg::OP_ORI:  res = a | {16'h0, word[15:0]};
         default:           wr = 1'b0;
      endcase
      if (wr && dst != 5'd0) begin
         model_regs[dst]             = res;
         exp_val[dst][exp_tail[dst]] = res;
         exp_tail[dst]++;
      end
   endtask

   // ADDI then ORI into r1..rn
   task automatic load_regs(input int n);
      for (int r = 1; r <= n; r++) begin
         emit(itype(mcpu_pkg::OP_ADDI, 5'(r), 5'd0, 16'(random_bits(16))));
         emit(itype(mcpu_pkg::OP_ORI, 5'(r), 5'(r), 16'(random_bits(16))));
      end
   endtask

   task automatic expect_addr(input logic [31:0] value);
      assert (imem_addr == value) else begin
         $display("Error: imem_addr expected %h, got %h", value, imem_addr);
         errors++;
      end
   endtask

   task automatic clear_program();
      prog_len = 0;
      for (int w = 0; w < ROM_WORDS; w++) begin
         rom[w] = '0;
      end
      for (int r = 0; r < 32; r++) begin
         model_regs[r] = '0;
         exp_head[r]   = 0;
         exp_tail[r]   = 0;
      end
   endtask

   // Reset is already high here, the program is built under reset
   task automatic run_program(input string name, input bit check_steps);
      int start_errors;
      int cycles;
      start_errors = errors;
      repeat (3) @(posedge clk);
      #1;
      expect_addr(32'h0);
      if_id_reset = 1'b0;
      @(negedge clk);
      expect_addr(32'h0);       // First cycle out of reset
      if (check_steps) begin
         for (int k = 1; k <= 4; k++) begin
            @(negedge clk);
            expect_addr(32'(k * 4));
         end
      end
      cycles = 0;
      while (imem_addr < (prog_len + 6) * 4 && cycles < DRAIN_MAX) begin
         @(negedge clk);
         cycles++;
      end
      if (imem_addr < (prog_len + 6) * 4) begin
         $display("Timeout: test %s did not drain within %0d cycles", name, DRAIN_MAX);
         errors++;
      end
      for (int r = 0; r < 32; r++) begin
         assert (exp_head[r] == exp_tail[r]) else begin
            $display("Register %0d never received %0d write(s)", r, exp_tail[r] - exp_head[r]);
            errors++;
         end
      end
      tests_run++;
      if (errors != start_errors) begin
         tests_failed++;
      end
      $display("%s: %0d error(s)", name, errors - start_errors);
      @(posedge clk);
      #1;
      if_id_reset = 1'b1;
      clear_program();
   endtask

   initial begin
      if_id_reset  = 1'b1;
      lfsr         = 16'd4;
      errors       = 0;
      checks       = 0;
      tests_run    = 0;
      tests_failed = 0;
      clear_program();
      run_program("reset", 1'b1);   // Zero words only, so the PC never stalls

      load_regs(4);
      emit(itype(mcpu_pkg::OP_ADDI, 5'd13, 5'd0, 16'hfff9));   // -7
      emit(rtype(mcpu_pkg::FN_ADD, 5'd5, 5'd1, 5'd2));
      emit(rtype(mcpu_pkg::FN_SUB, 5'd6, 5'd1, 5'd2));
      emit(rtype(mcpu_pkg::FN_AND, 5'd7, 5'd3, 5'd4));
      emit(rtype(mcpu_pkg::FN_OR, 5'd8, 5'd3, 5'd4));
      emit(rtype(mcpu_pkg::FN_SLT, 5'd9, 5'd13, 5'd1));
      emit(rtype(mcpu_pkg::FN_SLT, 5'd10, 5'd1, 5'd13));
      emit(rtype(mcpu_pkg::FN_SLT, 5'd14, 5'd2, 5'd3));
      emit(itype(mcpu_pkg::OP_ADDI, 5'd11, 5'd2, 16'h8003));
      emit(itype(mcpu_pkg::OP_ORI, 5'd12, 5'd4, 16'hc35a));
      run_program("alu", 1'b0);

      load_regs(6);
      emit(itype(mcpu_pkg::OP_ADDI, 5'd11, 5'd0, 16'hffff));   // All ones
      emit(rtype(mcpu_pkg::FN_MUL, 5'd7, 5'd1, 5'd2));         // Three in flight
      emit(rtype(mcpu_pkg::FN_MUL, 5'd8, 5'd3, 5'd4));
      emit(rtype(mcpu_pkg::FN_MUL, 5'd9, 5'd5, 5'd6));
      emit(rtype(mcpu_pkg::FN_MUL, 5'd10, 5'd11, 5'd1));
      run_program("mul", 1'b0);

      load_regs(2);
      emit(rtype(mcpu_pkg::FN_MUL, 5'd3, 5'd1, 5'd2));
      emit(rtype(mcpu_pkg::FN_ADD, 5'd4, 5'd3, 5'd1));
      emit(rtype(mcpu_pkg::FN_MUL, 5'd5, 5'd4, 5'd2));
      emit(rtype(mcpu_pkg::FN_SUB, 5'd6, 5'd5, 5'd3));
      emit(itype(mcpu_pkg::OP_ADDI, 5'd6, 5'd6, 16'h0003));
      emit(rtype(mcpu_pkg::FN_MUL, 5'd7, 5'd6, 5'd6));
      run_program("raw_chain", 1'b0);

      load_regs(7);
      emit(rtype(mcpu_pkg::FN_MUL, 5'd1, 5'd2, 5'd3));
      emit(rtype(mcpu_pkg::FN_ADD, 5'd4, 5'd5, 5'd6));
      emit(rtype(mcpu_pkg::FN_SUB, 5'd5, 5'd6, 5'd7));   // Lands on the MUL write slot
      for (int k = 0; k < 16; k++) begin
         d  = 5'(random_bits(3) % 7 + 1);
         s1 = 5'(random_bits(3));
         s2 = 5'(random_bits(3));
         case (random_bits(2))
            0, 1:    emit(rtype(mcpu_pkg::FN_MUL, d, s1, s2));
            2:       emit(rtype(mcpu_pkg::FN_ADD, d, s1, s2));
            default: emit(itype(mcpu_pkg::OP_ORI, d, s1, 16'(random_bits(16))));
         endcase
      end
      run_program("mixed", 1'b0);

      load_regs(2);
      emit(rtype(mcpu_pkg::FN_ADD, 5'd0, 5'd1, 5'd2));
      emit(rtype(mcpu_pkg::FN_MUL, 5'd0, 5'd1, 5'd2));
      emit(itype(mcpu_pkg::OP_ADDI, 5'd0, 5'd1, 16'h0005));
      emit({6'd63, 5'd1, 5'd5, 16'h1234});                 // Unsupported opcode
      emit(rtype(6'd0, 5'd6, 5'd1, 5'd2));                 // Unknown funct
      emit(rtype(mcpu_pkg::FN_ADD, 5'd3, 5'd0, 5'd0));
      emit(rtype(mcpu_pkg::FN_ADD, 5'd4, 5'd0, 5'd1));
      run_program("noop", 1'b0);

      $display("tests %0d, failed %0d, retire checks %0d, errors %0d",
               tests_run, tests_failed, checks, errors);
      if (errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

/* source/mcpu_top.sv */
`timescale 1ns/1ps

module mcpu_top (
   input  logic                      clk,
   input  logic                      if_id_reset,
   output logic [mcpu_pkg::XLEN-1:0] imem_addr,
   input  mcpu_pkg::instr_t          imem_data,
   output mcpu_pkg::wb_t             retire
);

   logic                            stall;
   mcpu_pkg::instr_t                if_instr;
   logic [mcpu_pkg::REG_ADDR_W-1:0] rs1_addr;
   logic [mcpu_pkg::REG_ADDR_W-1:0] rs2_addr;
   logic [mcpu_pkg::XLEN-1:0]       rs1_data;
   logic [mcpu_pkg::XLEN-1:0]       rs2_data;
   mcpu_pkg::issue_req_t            req;
   mcpu_pkg::id_ex_t                id_ex;
   mcpu_pkg::wb_t                   alu_wb;
   mcpu_pkg::wb_t                   mul_wb;

   fetch_unit u_fetch (
      .clk(clk), .if_id_reset(if_id_reset), .stall(stall),
      .imem_data(imem_data), .pc(imem_addr), .if_instr(if_instr)
   );

   decode_stage u_decode (
      .clk(clk), .if_id_reset(if_id_reset), .stall(stall), .if_instr(if_instr),
      .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rs1_data(rs1_data), .rs2_data(rs2_data),
      .req(req), .id_ex(id_ex)
   );

   reg_file u_regs (
      .clk(clk), .if_id_reset(if_id_reset), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
      .rs1_data(rs1_data), .rs2_data(rs2_data), .alu_wb(alu_wb), .mul_wb(mul_wb),
      .retire(retire)
   );

   alu_stage u_alu (.clk(clk), .if_id_reset(if_id_reset), .id_ex(id_ex), .alu_wb(alu_wb));

   mul_pipe u_mul (.clk(clk), .if_id_reset(if_id_reset), .id_ex(id_ex), .mul_wb(mul_wb));

   hazard_control u_hazard (
      .clk(clk), .if_id_reset(if_id_reset), .req(req), .retire(retire), .stall(stall)
   );

endmodule

/* source/hazard_control.sv */
`timescale 1ns/1ps

module hazard_control (
   input  logic                 clk,
   input  logic                 if_id_reset,
   input  mcpu_pkg::issue_req_t req,
   input  mcpu_pkg::wb_t        retire,
   output logic                 stall
);

   logic [mcpu_pkg::NUM_REGS-1:0]   pending;   // One pending bit per register
   logic [mcpu_pkg::MUL_STAGES-2:0] mul_age;   // Bit k set when a MUL issued k+1 cycles ago
   logic                            writes;
   logic                            reg_busy;
   logic                            slot_clash;
   logic                            issue;

   assign writes = (req.dest != '0);

   // Dest check covers WAW between ALU and MUL
   assign reg_busy = pending[req.src1]
                   | (req.uses_src2 & pending[req.src2])
                   | pending[req.dest];

   // ALU result lands 2 cycles after issue and MUL result MUL_STAGES+1 after
   // so an ALU issue collides with a MUL issued MUL_STAGES-1 cycles earlier
   assign slot_clash = writes && !req.is_mul && mul_age[mcpu_pkg::MUL_STAGES-2];

   assign stall = req.valid && (reg_busy || slot_clash);
   assign issue = req.valid && !stall;

   always_ff @(posedge clk) begin
      if (if_id_reset) begin
         pending <= '0;
         mul_age <= '0;
      end else begin
         mul_age <= {mul_age[mcpu_pkg::MUL_STAGES-3:0], issue && writes && req.is_mul};
         if (retire.valid) begin
            pending[retire.dest] <= 1'b0;
         end
         // Issuing dest is never pending, so it cannot clash with the clear
         if (issue && writes) begin
            pending[req.dest] <= 1'b1;
         end
      end
   end

endmodule

/* source/mul_pipe.sv */
`timescale 1ns/1ps

module mul_pipe (
   input  logic             clk,
   input  logic             if_id_reset,
   input  mcpu_pkg::id_ex_t id_ex,
   output mcpu_pkg::wb_t    mul_wb
);

   localparam int H = mcpu_pkg::HALF_W;

   logic                            s1_valid;
   logic [mcpu_pkg::REG_ADDR_W-1:0] s1_dest;
   logic [2*H-1:0]                  pp_ll;
   logic [H-1:0]                    pp_lh;   // Only low half of cross terms reaches bit 31
   logic [H-1:0]                    pp_hl;
   logic                            s2_valid;
   logic [mcpu_pkg::REG_ADDR_W-1:0] s2_dest;
   logic [mcpu_pkg::XLEN-1:0]       s2_lo;

   always_ff @(posedge clk) begin
      if (if_id_reset) begin
         s1_valid <= 1'b0;
         s2_valid <= 1'b0;
         mul_wb.valid <= 1'b0;
      end else begin
         s1_valid <= id_ex.valid && id_ex.is_mul;
         s2_valid <= s1_valid;
         mul_wb.valid <= s2_valid;
      end

      // Stage 1: partial products
      // High-by-high term only affects bits 32 and up, so it is not formed
      s1_dest <= id_ex.dest;
      pp_ll   <= id_ex.op_a[H-1:0] * id_ex.op_b[H-1:0];
      pp_lh   <= id_ex.op_a[H-1:0] * id_ex.op_b[2*H-1:H];
      pp_hl   <= id_ex.op_a[2*H-1:H] * id_ex.op_b[H-1:0];

      // Stage 2: low word of the product
      s2_dest <= s1_dest;
      s2_lo   <= pp_ll + {pp_lh + pp_hl, {H{1'b0}}};

      // Stage 3: writeback register
      mul_wb.dest <= s2_dest;
      mul_wb.data <= s2_lo;
   end

endmodule

/* source/alu_stage.sv */
`timescale 1ns/1ps

module alu_stage (
   input  logic             clk,
   input  logic             if_id_reset,
   input  mcpu_pkg::id_ex_t id_ex,
   output mcpu_pkg::wb_t    alu_wb
);

   logic [mcpu_pkg::XLEN-1:0] result;
   logic                      less;

   assign less = $signed(id_ex.op_a) < $signed(id_ex.op_b);

   always_comb begin
      case (id_ex.alu_op)
         mcpu_pkg::ALU_ADD: result = id_ex.op_a + id_ex.op_b;
         mcpu_pkg::ALU_SUB: result = id_ex.op_a - id_ex.op_b;
         mcpu_pkg::ALU_AND: result = id_ex.op_a & id_ex.op_b;
         mcpu_pkg::ALU_OR:  result = id_ex.op_a | id_ex.op_b;
         mcpu_pkg::ALU_SLT: result = {{(mcpu_pkg::XLEN-1){1'b0}}, less};
         default:           result = id_ex.op_a + id_ex.op_b;
      endcase
   end

   // Writeback register, one cycle behind ID/EX
   always_ff @(posedge clk) begin
      if (if_id_reset) begin
         alu_wb.valid <= 1'b0;
      end else begin
         alu_wb.valid <= id_ex.valid && !id_ex.is_mul;   // MUL items belong to mul_pipe
      end
      alu_wb.dest <= id_ex.dest;
      alu_wb.data <= result;
   end

endmodule

/* source/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
   input  logic                            clk,
   input  logic                            if_id_reset,
   input  logic [mcpu_pkg::REG_ADDR_W-1:0] rs1_addr,
   input  logic [mcpu_pkg::REG_ADDR_W-1:0] rs2_addr,
   output logic [mcpu_pkg::XLEN-1:0]       rs1_data,
   output logic [mcpu_pkg::XLEN-1:0]       rs2_data,
   input  mcpu_pkg::wb_t                   alu_wb,
   input  mcpu_pkg::wb_t                   mul_wb,
   output mcpu_pkg::wb_t                   retire
);

   logic [mcpu_pkg::XLEN-1:0] regs [mcpu_pkg::NUM_REGS];

   // At most one source is valid per cycle, hazard_control keeps them apart
   assign retire = alu_wb.valid ? alu_wb : mul_wb;

   // r0 always reads as zero
   assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
   assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

   always_ff @(posedge clk) begin
      if (if_id_reset) begin
         for (int i = 0; i < mcpu_pkg::NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (retire.valid) begin
         regs[retire.dest] <= retire.data;
      end
   end

endmodule

/* source/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
   input  logic                           clk,
   input  logic                           if_id_reset,
   input  logic                           stall,
   input  mcpu_pkg::instr_t               if_instr,
   output logic [mcpu_pkg::REG_ADDR_W-1:0] rs1_addr,
   output logic [mcpu_pkg::REG_ADDR_W-1:0] rs2_addr,
   input  logic [mcpu_pkg::XLEN-1:0]      rs1_data,
   input  logic [mcpu_pkg::XLEN-1:0]      rs2_data,
   output mcpu_pkg::issue_req_t           req,
   output mcpu_pkg::id_ex_t               id_ex
);

   mcpu_pkg::alu_op_t           alu_op;
   logic [mcpu_pkg::XLEN-1:0]   imm_ext;

   // rs and rt sit at the same bits in both formats
   assign rs1_addr = if_instr.r.rs;
   assign rs2_addr = if_instr.r.rt;

   always_comb begin
      req       = '0;
      alu_op    = mcpu_pkg::ALU_ADD;
      imm_ext   = '0;
      req.src1  = if_instr.r.rs;
      req.src2  = if_instr.r.rt;
      case (if_instr.r.opcode)
         mcpu_pkg::OP_RTYPE: begin
            req.valid     = 1'b1;
            req.uses_src2 = 1'b1;
            req.dest      = if_instr.r.rd;
            case (if_instr.r.funct)
               mcpu_pkg::FN_ADD: alu_op = mcpu_pkg::ALU_ADD;
               mcpu_pkg::FN_SUB: alu_op = mcpu_pkg::ALU_SUB;
               mcpu_pkg::FN_AND: alu_op = mcpu_pkg::ALU_AND;
               mcpu_pkg::FN_OR:  alu_op = mcpu_pkg::ALU_OR;
               mcpu_pkg::FN_SLT: alu_op = mcpu_pkg::ALU_SLT;
               mcpu_pkg::FN_MUL: req.is_mul = 1'b1;
               default:          req.valid = 1'b0;   // Unknown funct
            endcase
         end
         mcpu_pkg::OP_ADDI: begin
            req.valid = 1'b1;
            req.dest  = if_instr.i.rt;
            imm_ext   = {{(mcpu_pkg::XLEN-16){if_instr.i.imm[15]}}, if_instr.i.imm};
         end
         mcpu_pkg::OP_ORI: begin
            req.valid = 1'b1;
            req.dest  = if_instr.i.rt;
            alu_op    = mcpu_pkg::ALU_OR;
            imm_ext   = {{(mcpu_pkg::XLEN-16){1'b0}}, if_instr.i.imm};   // Zero extended
         end
         default: begin
         end
      endcase
   end

   // ID/EX register, bubble while stalled
   always_ff @(posedge clk) begin
      if (if_id_reset) begin
         id_ex.valid  <= 1'b0;
         id_ex.is_mul <= 1'b0;
      end else begin
         // Writes to r0 are dropped here and never reach execute
         id_ex.valid  <= req.valid && !stall && (req.dest != '0);
         id_ex.is_mul <= req.is_mul;
      end
      id_ex.alu_op <= alu_op;
      id_ex.dest   <= req.dest;
      id_ex.op_a   <= rs1_data;
      id_ex.op_b   <= req.uses_src2 ? rs2_data : imm_ext;
   end

endmodule

/* source/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit (
   input  logic                     clk,
   input  logic                     if_id_reset,
   input  logic                     stall,
   input  mcpu_pkg::instr_t         imem_data,
   output logic [mcpu_pkg::XLEN-1:0] pc,
   output mcpu_pkg::instr_t         if_instr
);

   // Program counter, byte addressed
   always_ff @(posedge clk) begin
      if (if_id_reset) begin
         pc <= '0;
      end else if (!stall) begin
         pc <= pc + mcpu_pkg::XLEN'(4);
      end
   end

   // IF/ID register
   // Zero word decodes as an unsupported R-type, so it acts as a no-op
   always_ff @(posedge clk) begin
      if (if_id_reset) begin
         if_instr <= '0;
      end else if (!stall) begin
         if_instr <= imem_data;   // Same word stays put while decode waits
      end
   end

endmodule

/* source/mcpu_pkg.sv */
package mcpu_pkg;

   localparam int XLEN       = 32;
   localparam int HALF_W     = XLEN / 2;   // Multiplier operand halves
   localparam int REG_ADDR_W = 5;
   localparam int NUM_REGS   = 32;
   localparam int MUL_STAGES = 3;

   // Major opcodes
   localparam logic [5:0] OP_RTYPE = 6'd0;
   localparam logic [5:0] OP_ADDI  = 6'd8;
   localparam logic [5:0] OP_ORI   = 6'd13;

   // R-type function codes
   localparam logic [5:0] FN_ADD = 6'd32;
   localparam logic [5:0] FN_SUB = 6'd34;
   localparam logic [5:0] FN_AND = 6'd36;
   localparam logic [5:0] FN_OR  = 6'd37;
   localparam logic [5:0] FN_SLT = 6'd42;
   localparam logic [5:0] FN_MUL = 6'd24;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_SLT
   } alu_op_t;

   typedef struct packed {
      logic [5:0]            opcode;
      logic [REG_ADDR_W-1:0] rs;
      logic [REG_ADDR_W-1:0] rt;
      logic [REG_ADDR_W-1:0] rd;
      logic [4:0]            shamt;
      logic [5:0]            funct;
   } r_fmt_t;

   typedef struct packed {
      logic [5:0]            opcode;
      logic [REG_ADDR_W-1:0] rs;
      logic [REG_ADDR_W-1:0] rt;
      logic [15:0]           imm;
   } i_fmt_t;

   // Same 32-bit word seen as R-type or I-type
   typedef union packed {
      r_fmt_t r;
      i_fmt_t i;
   } instr_t;

   typedef struct packed {
      logic                  valid;
      logic [REG_ADDR_W-1:0] src1;
      logic [REG_ADDR_W-1:0] src2;
      logic                  uses_src2;
      logic [REG_ADDR_W-1:0] dest;      // Zero means no write
      logic                  is_mul;
   } issue_req_t;

   typedef struct packed {
      logic                  valid;
      logic                  is_mul;
      alu_op_t               alu_op;
      logic [REG_ADDR_W-1:0] dest;
      logic [XLEN-1:0]       op_a;
      logic [XLEN-1:0]       op_b;      // Immediate already extended
   } id_ex_t;

   typedef struct packed {
      logic                  valid;
      logic [REG_ADDR_W-1:0] dest;
      logic [XLEN-1:0]       data;
   } wb_t;

endpackage
